/* include/sprite_settings.svh */
`ifndef SPRITE_SETTINGS_SVH
`define SPRITE_SETTINGS_SVH

// sprite engine sizing
`define SPRITE_COUNT 8          // hardware sprites, four pairs
`define HPOS_WIDTH 9            // horizontal beam counter
`define SPRITE_DATA_WIDTH 16    // one data word, also bus data width

// register bus
`define REG_ADDR_WIDTH 6        // 0..31 sprite regs, 32 mask
`define SPRITE_MASK_ADDR 6'd32  // global sprite mask register

`endif

/* hw/sprite_pkg.sv */
`default_nettype none

// shared types for the sprite engine
package sprite_pkg;

  // --------------------
  // per-sprite register select, address bits 1..0
  // --------------------
  typedef enum logic [1:0] {
    spr_pos  = 2'b00,  // hstart bits 8..1
    spr_ctl  = 2'b01,  // attach, hstart bit 0; disarms
    spr_data = 2'b10,  // plane a word; arms
    spr_datb = 2'b11   // plane b word
  } sprite_reg_e;

  // --------------------
  // how the winning pixel of a pair was formed
  // --------------------
  typedef enum logic {
    mode_single   = 1'b0,  // one sprite, 3 colors + transparent
    mode_attached = 1'b1   // odd over even, 15 colors + transparent
  } pixel_mode_e;

  // color index layout in the 16-entry sprite palette
  //   single    {pair, 2-bit pixel}
  //   attached  {odd pixel, even pixel}
  // pair 0 covers sprites 0/1, pair 3 covers sprites 6/7

endpackage

`default_nettype wire

/* hw/sprite_reg_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sprite_settings.svh"

// register bus decode
// sprite writes become a one-hot strobe to the shifters, one enabled cycle later
module sprite_reg_decode (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            pix_en,      // pixel clock enable
  input  logic                            reg_wr,      // single-cycle write strobe
  input  logic [`REG_ADDR_WIDTH-1:0]      reg_addr,
  input  logic [`SPRITE_DATA_WIDTH-1:0]   reg_data,
  output logic [`SPRITE_COUNT-1:0]        spr_wr,      // one-hot per sprite
  output sprite_pkg::sprite_reg_e         spr_reg,
  output logic [`SPRITE_DATA_WIDTH-1:0]   spr_data,
  output logic [`SPRITE_COUNT-1:0]        sprite_mask  // 1 = sprite visible
);

  import sprite_pkg::*;

  logic sprite_hit;  // address in sprite register window
  logic mask_hit;    // address is the global mask

  // --------------------
  // address decode
  // --------------------
  assign sprite_hit = reg_wr && !reg_addr[5];                   // 0..31
  assign mask_hit   = reg_wr && (reg_addr == `SPRITE_MASK_ADDR);

  // strobe lasts exactly one enabled cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      spr_wr <= '0;
    end else if (pix_en) begin
      spr_wr <= '0;
      if (sprite_hit)
        spr_wr[reg_addr[4:2]] <= 1'b1;  // sprite number in bits 4..2
    end
  end

  // register select and data ride along with the strobe
  always_ff @(posedge clk) begin
    if (pix_en && sprite_hit) begin
      spr_reg  <= sprite_reg_e'(reg_addr[1:0]);
      spr_data <= reg_data;
    end
  end

  // --------------------
  // global sprite mask
  // --------------------
  always_ff @(posedge clk) begin
    if (reset)
      sprite_mask <= '1;  // all sprites visible
    else if (pix_en && mask_hit)
      sprite_mask <= reg_data[`SPRITE_COUNT-1:0];
  end

  // addresses 33..63 fall through, nothing happens

endmodule

`default_nettype wire

/* hw/sprite_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sprite_settings.svh"

// one sprite's registers, arming and parallel to serial conversion
// the load pipeline is two stages deep so that bit 15 shows
// while hpos equals hstart + 3
module sprite_shifter (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            pix_en,   // pixel clock enable
  input  logic                            wr,       // decoded write strobe
  input  sprite_pkg::sprite_reg_e         reg_sel,  // register being written
  input  logic [`SPRITE_DATA_WIDTH-1:0]   data_in,
  input  logic [`HPOS_WIDTH-1:0]          hpos,     // horizontal beam counter
  output logic [1:0]                      sprdata,  // {plane b, plane a}
  output logic                            attach    // odd sprite joins its neighbor
);

  import sprite_pkg::*;

  logic [`SPRITE_DATA_WIDTH-1:0] datla;   // data register a
  logic [`SPRITE_DATA_WIDTH-1:0] datlb;   // data register b
  logic [`SPRITE_DATA_WIDTH-1:0] shifta;  // shift register a
  logic [`SPRITE_DATA_WIDTH-1:0] shiftb;  // shift register b
  logic [`HPOS_WIDTH-1:0]        hstart;  // horizontal start
  logic                          armed;
  logic                          load;     // start match seen
  logic                          load_del; // loads the shifters

  // --------------------
  // arming
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;  // nothing triggers out of reset
    end else if (pix_en && wr) begin
      if (reg_sel == spr_ctl)
        armed <= 1'b0;  // ctl write disarms
      else if (reg_sel == spr_data)
        armed <= 1'b1;  // data a write arms
    end
  end

  // start position compare and its delay stage
  // stays armed, so the sprite retriggers every line
  always_ff @(posedge clk) begin
    if (reset) begin
      load     <= 1'b0;
      load_del <= 1'b0;
    end else if (pix_en) begin
      load     <= armed && (hpos == hstart);
      load_del <= load;
    end
  end

  // --------------------
  // register file
  // --------------------
  always_ff @(posedge clk) begin
    if (pix_en && wr) begin
      case (reg_sel)
        spr_pos:  hstart[8:1] <= data_in[7:0];
        spr_ctl:  hstart[0]   <= data_in[0];
        spr_data: datla       <= data_in;
        spr_datb: datlb       <= data_in;
        default:  ;
      endcase
    end
  end

  // attach bit sits in ctl bit 7
  always_ff @(posedge clk) begin
    if (reset)
      attach <= 1'b0;
    else if (pix_en && wr && (reg_sel == spr_ctl))
      attach <= data_in[7];
  end

  // --------------------
  // shifters, msb first
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      shifta <= '0;
      shiftb <= '0;
    end else if (pix_en) begin
      if (load_del) begin
        shifta <= datla;  // fresh words from the data regs
        shiftb <= datlb;
      end else begin
        shifta <= {shifta[`SPRITE_DATA_WIDTH-2:0], 1'b0};  // zeros fill in behind
        shiftb <= {shiftb[`SPRITE_DATA_WIDTH-2:0], 1'b0};
      end
    end
  end

  // serial pixel out
  assign sprdata = {shiftb[`SPRITE_DATA_WIDTH-1], shifta[`SPRITE_DATA_WIDTH-1]};

endmodule

`default_nettype wire

/* hw/sprite_priority.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sprite_settings.svh"

// priority merge of all sprite pixel streams
// lowest pair wins, odd sprite may attach to the even one
module sprite_priority (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            pix_en,       // pixel clock enable
  input  logic [2*`SPRITE_COUNT-1:0]      sprdata,      // two bits per sprite
  input  logic [`SPRITE_COUNT-1:0]        attach,       // only odd bits matter
  input  logic [`SPRITE_COUNT-1:0]        sprite_mask,  // 1 = visible
  output logic [3:0]                      spr_color,    // sprite palette index
  output logic                            spr_valid,
  output sprite_pkg::pixel_mode_e         spr_mode
);

  import sprite_pkg::*;

  localparam int PAIR_COUNT = `SPRITE_COUNT / 2;

  logic [1:0]  pix [`SPRITE_COUNT];  // masked pixels
  logic [3:0]  color_nxt;
  logic        valid_nxt;
  pixel_mode_e mode_nxt;

  // --------------------
  // masking
  // --------------------
  always_comb begin
    for (int i = 0; i < `SPRITE_COUNT; i++) begin
      pix[i] = sprite_mask[i] ? sprdata[2*i +: 2] : 2'b00;  // hidden = transparent
    end
  end

  // --------------------
  // pair scan
  // --------------------
  // walks from the highest pair down so the lowest
  // pair with a pixel is written last and wins
  always_comb begin
    color_nxt = 4'd0;
    valid_nxt = 1'b0;
    mode_nxt  = mode_single;
    for (int p = PAIR_COUNT - 1; p >= 0; p--) begin
      if ((pix[2*p] != 2'b00) || (pix[2*p+1] != 2'b00)) begin
        valid_nxt = 1'b1;
        if (attach[2*p+1]) begin
          // 15-color pixel, odd bits on top
          color_nxt = {pix[2*p+1], pix[2*p]};
          mode_nxt  = mode_attached;
        end else if (pix[2*p] != 2'b00) begin
          color_nxt = {p[1:0], pix[2*p]};    // even sprite in front
          mode_nxt  = mode_single;
        end else begin
          color_nxt = {p[1:0], pix[2*p+1]};  // odd shows through
          mode_nxt  = mode_single;
        end
      end
    end
  end

  // --------------------
  // output register, one enabled cycle
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      spr_color <= 4'd0;
      spr_valid <= 1'b0;
      spr_mode  <= mode_single;
    end else if (pix_en) begin
      spr_color <= color_nxt;  // 0 when nothing is showing
      spr_valid <= valid_nxt;
      spr_mode  <= mode_nxt;
    end
  end

endmodule

`default_nettype wire

/* hw/sprite_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sprite_settings.svh"

// sprite serializer top
// bus decode -> eight shifters -> priority merge
// pixel bit 15 of a sprite reaches the outputs while hpos equals hstart + 4
module sprite_engine (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            pix_en,    // pixel clock enable
  input  logic [`HPOS_WIDTH-1:0]          hpos,      // beam counter
  input  logic                            reg_wr,    // bus write strobe
  input  logic [`REG_ADDR_WIDTH-1:0]      reg_addr,
  input  logic [`SPRITE_DATA_WIDTH-1:0]   reg_data,
  output logic [3:0]                      spr_color,
  output logic                            spr_valid,
  output sprite_pkg::pixel_mode_e         spr_mode
);

  import sprite_pkg::*;

  // decoder to shifters
  logic [`SPRITE_COUNT-1:0]        spr_wr;
  sprite_reg_e                     spr_reg;
  logic [`SPRITE_DATA_WIDTH-1:0]   spr_data;
  logic [`SPRITE_COUNT-1:0]        sprite_mask;

  // shifters to priority merge
  logic [2*`SPRITE_COUNT-1:0]      sprdata;
  logic [`SPRITE_COUNT-1:0]        attach;

  // --------------------
  // register decode
  // --------------------
  sprite_reg_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .pix_en      (pix_en),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_data    (reg_data),
    .spr_wr      (spr_wr),
    .spr_reg     (spr_reg),
    .spr_data    (spr_data),
    .sprite_mask (sprite_mask)
  );

  // --------------------
  // one shifter per sprite
  // --------------------
  for (genvar i = 0; i < `SPRITE_COUNT; i++) begin : g_sprite
    sprite_shifter u_shifter (
      .clk     (clk),
      .reset   (reset),
      .pix_en  (pix_en),
      .wr      (spr_wr[i]),          // own strobe bit
      .reg_sel (spr_reg),
      .data_in (spr_data),
      .hpos    (hpos),
      .sprdata (sprdata[2*i +: 2]),
      .attach  (attach[i])
    );
  end

  // --------------------
  // priority merge
  // --------------------
  sprite_priority u_priority (
    .clk         (clk),
    .reset       (reset),
    .pix_en      (pix_en),
    .sprdata     (sprdata),
    .attach      (attach),
    .sprite_mask (sprite_mask),
    .spr_color   (spr_color),
    .spr_valid   (spr_valid),
    .spr_mode    (spr_mode)
  );

endmodule

`default_nettype wire

/* verification/sprite_engine_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sprite_settings.svh"

module sprite_engine_tb;

  import sprite_pkg::*;

  localparam int CLK_HALF    = 50;
  localparam int LINE_CYCLES = 400;  // hpos wraps here
  localparam int TEST_LINES  = 32;   // all six tests, gaps stretch test 5
  localparam int SPARE_LINES = 12;

  logic                          clk    = 1'b0;
  logic                          reset;
  logic                          pix_en = 1'b1;
  logic [`HPOS_WIDTH-1:0]        hpos   = '0;
  logic                          reg_wr;
  logic [`REG_ADDR_WIDTH-1:0]    reg_addr;
  logic [`SPRITE_DATA_WIDTH-1:0] reg_data;
  logic [3:0]                    spr_color;
  logic                          spr_valid;
  pixel_mode_e                   spr_mode;

  logic  gaps_on;   // random pix_en gaps
  logic  pix_hold;  // forces pix_en low
  string test_name;
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;

  // expected top outputs
  logic [3:0]  exp_color;
  logic        exp_valid;
  pixel_mode_e exp_mode;

  // reference model state, one entry per sprite
  logic [8:0]               m_hstart [`SPRITE_COUNT];
  logic [15:0]              m_da [`SPRITE_COUNT];
  logic [15:0]              m_db [`SPRITE_COUNT];
  logic [15:0]              m_sa [`SPRITE_COUNT];  // words on display
  logic [15:0]              m_sb [`SPRITE_COUNT];
  logic [4:0]               m_idx [`SPRITE_COUNT];  // pixel number, 16 = done
  logic [`SPRITE_COUNT-1:0] m_armed;
  logic [`SPRITE_COUNT-1:0] m_attach;
  logic [`SPRITE_COUNT-1:0] m_match;  // start seen
  logic [`SPRITE_COUNT-1:0] m_start;  // one edge later
  logic [`SPRITE_COUNT-1:0] m_mask;
  logic                     p_valid;  // decoded write in flight
  logic [2:0]               p_num;
  sprite_reg_e              p_reg;
  logic [15:0]              p_data;

  sprite_engine dut (
    .clk       (clk),
    .reset     (reset),
    .pix_en    (pix_en),
    .hpos      (hpos),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_data  (reg_data),
    .spr_color (spr_color),
    .spr_valid (spr_valid),
    .spr_mode  (spr_mode)
  );

  always #CLK_HALF clk = ~clk;

  // --------------------
  // beam counter and pixel enable
  // --------------------
  always @(posedge clk) begin
    if (reset)
      hpos <= '0;
    else if (pix_en)
      hpos <= (hpos == 9'(LINE_CYCLES - 1)) ? '0 : hpos + 9'd1;
  end

  always @(posedge clk) begin
    if (pix_hold)
      pix_en <= 1'b0;
    else if (gaps_on)
      pix_en <= ($urandom % 4) != 0;  // about one cycle in four idle
    else
      pix_en <= 1'b1;
  end

  // --------------------
  // reference model
  // --------------------
  always @(posedge clk) begin
    logic [1:0]  px [`SPRITE_COUNT];
    logic [3:0]  b;
    logic [3:0]  c;
    logic        v;
    pixel_mode_e md;
    if (reset) begin
      for (int i = 0; i < `SPRITE_COUNT; i++) begin
        m_idx[i]    = 5'd16;
        m_hstart[i] = '0;
        m_da[i]     = '0;
        m_db[i]     = '0;
      end
      m_armed   = '0;
      m_attach  = '0;
      m_match   = '0;
      m_start   = '0;
      m_mask    = '1;   // all visible
      p_valid   = 1'b0;
      exp_color <= 4'd0;
      exp_valid <= 1'b0;
      exp_mode  <= mode_single;
    end else if (pix_en) begin
      // pixels on display right now, after the mask
      for (int i = 0; i < `SPRITE_COUNT; i++) begin
        b = ~m_idx[i][3:0];  // bit 15 first
        if (m_idx[i][4] || !m_mask[i])
          px[i] = 2'b00;
        else
          px[i] = {m_sb[i][b], m_sa[i][b]};
      end
      // lowest pair with any pixel wins
      c  = 4'd0;
      v  = 1'b0;
      md = mode_single;
      for (int p = 0; p < `SPRITE_COUNT / 2; p++) begin
        if (!v && (px[2*p] != 2'b00 || px[2*p+1] != 2'b00)) begin
          v = 1'b1;
          if (m_attach[2*p+1]) begin
            c  = {px[2*p+1], px[2*p]};  // 15-color pixel
            md = mode_attached;
          end else if (px[2*p] != 2'b00)
            c = 4'(4 * p) + {2'b00, px[2*p]};
          else
            c = 4'(4 * p) + {2'b00, px[2*p+1]};
        end
      end
      exp_color <= c;
      exp_valid <= v;
      exp_mode  <= md;
      // words reload two edges after the start match
      for (int i = 0; i < `SPRITE_COUNT; i++) begin
        if (m_start[i]) begin
          m_sa[i]  = m_da[i];
          m_sb[i]  = m_db[i];
          m_idx[i] = 5'd0;
        end else if (!m_idx[i][4])
          m_idx[i] = m_idx[i] + 5'd1;
      end
      m_start = m_match;
      for (int i = 0; i < `SPRITE_COUNT; i++)
        m_match[i] = m_armed[i] && (hpos == m_hstart[i]);
      // write decoded last enabled edge lands now
      if (p_valid) begin
        case (p_reg)
          spr_pos: m_hstart[p_num][8:1] = p_data[7:0];
          spr_ctl: begin
            m_hstart[p_num][0] = p_data[0];
            m_attach[p_num]    = p_data[7];
            m_armed[p_num]     = 1'b0;
          end
          spr_data: begin
            m_da[p_num]    = p_data;
            m_armed[p_num] = 1'b1;
          end
          default: m_db[p_num] = p_data;
        endcase
      end
      p_valid = reg_wr && !reg_addr[5];
      p_num   = reg_addr[4:2];
      p_reg   = sprite_reg_e'(reg_addr[1:0]);
      p_data  = reg_data;
      if (reg_wr && reg_addr == `SPRITE_MASK_ADDR)
        m_mask = reg_data[`SPRITE_COUNT-1:0];  // mask acts right away
    end
  end

  // --------------------
  // checks
  // --------------------
  function automatic void report_mismatch(string what, int want, int got);
    $display("ERR %s %s expected %0h actual %0h", test_name, what, want, got);
    errors++;
  endfunction

  assert property (@(posedge clk) disable iff (reset) spr_valid == exp_valid)
    else report_mismatch("spr_valid", int'($sampled(exp_valid)), int'($sampled(spr_valid)));
  assert property (@(posedge clk) disable iff (reset) spr_color == exp_color)
    else report_mismatch("spr_color", int'($sampled(exp_color)), int'($sampled(spr_color)));
  assert property (@(posedge clk) disable iff (reset) spr_mode == exp_mode)
    else report_mismatch("spr_mode", int'($sampled(exp_mode)), int'($sampled(spr_mode)));

  // --------------------
  // bus helpers
  // --------------------
  function automatic logic [5:0] reg_address(int n, sprite_reg_e r);
    return {1'b0, 3'(n), r};
  endfunction

  task automatic bus_write(logic [5:0] addr, logic [15:0] data);
    @(posedge clk);
    reg_wr   <= 1'b1;
    reg_addr <= addr;
    reg_data <= data;
    @(posedge clk);
    while (!pix_en) @(posedge clk);  // held until an enabled edge takes it
    reg_wr <= 1'b0;
  endtask

  // strobe in a cycle with pix_en low, must be dropped
  task automatic stray_write(logic [5:0] addr, logic [15:0] data);
    @(posedge clk);
    pix_hold <= 1'b1;
    @(posedge clk);
    reg_wr   <= 1'b1;
    reg_addr <= addr;
    reg_data <= data;
    @(posedge clk);
    reg_wr   <= 1'b0;
    pix_hold <= 1'b0;
  endtask

  task automatic place_sprite(int n, logic [8:0] hs, logic att, logic [15:0] da,
                              logic [15:0] db);
    bus_write(reg_address(n, spr_pos), {8'h00, hs[8:1]});
    bus_write(reg_address(n, spr_ctl), {8'h00, att, 6'b0, hs[0]});
    bus_write(reg_address(n, spr_datb), db);
    bus_write(reg_address(n, spr_data), da);  // arms last
  endtask

  task automatic disarm_all();
    for (int n = 0; n < `SPRITE_COUNT; n++)
      bus_write(reg_address(n, spr_ctl), 16'h0000);
  endtask

  task automatic wait_lines(int n);
    repeat (n) begin
      @(posedge clk);
      while (hpos != 9'(LINE_CYCLES - 1)) @(posedge clk);
      while (hpos != 9'd0) @(posedge clk);
    end
  endtask

  // bit 15 must be on the outputs while hpos equals hstart + 4
  task automatic first_pixel_at(logic [8:0] target, logic [3:0] want);
    int waited;
    waited = 0;
    @(negedge clk);
    while (hpos != target && waited < 2 * LINE_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (hpos != target) begin
      $display("%s: hpos never reached the first pixel position", test_name);
      errors++;
    end else begin
      assert (spr_valid && spr_color == want)
        else report_mismatch("first pixel", int'({1'b1, want}), int'({spr_valid, spr_color}));
    end
  endtask

  task automatic open_test(string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic close_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic reset_and_arming();
    open_test("reset_arming");
    wait_lines(1);  // nothing written yet
    place_sprite(2, 9'd60, 1'b0, 16'hFFFF, 16'hFFFF);
    bus_write(reg_address(2, spr_ctl), 16'h0000);  // ctl again, so disarmed
    wait_lines(1);
    place_sprite(0, 9'd100, 1'b0, 16'hA5C3, 16'h8F0F);
    first_pixel_at(9'd104, 4'b0011);
    wait_lines(2);  // retriggers every line
    close_test();
  endtask

  task automatic pair_priority();
    open_test("priority");
    disarm_all();
    place_sprite(2, 9'd150, 1'b0, 16'hFFFF, 16'h0000);
    place_sprite(5, 9'd154, 1'b0, 16'hFFFF, 16'hFFFF);  // tail past sprite 2
    place_sprite(0, 9'd200, 1'b0, 16'hF0F0, 16'h0000);  // gaps let 1 through
    place_sprite(1, 9'd200, 1'b0, 16'hFFFF, 16'hFF00);
    wait_lines(2);
    close_test();
  endtask

  task automatic attached_pairs();
    int         pair;
    logic [8:0] hs;
    open_test("attach");
    repeat (4) begin
      pair = $urandom % 4;
      hs   = 9'($urandom % 380);
      disarm_all();
      place_sprite(2 * pair, hs, 1'b0, 16'($urandom), 16'($urandom));
      place_sprite(2 * pair + 1, hs, 1'b1, 16'($urandom), 16'($urandom));
      wait_lines(2);
    end
    close_test();
  endtask

  task automatic global_mask();
    open_test("mask");
    disarm_all();
    place_sprite(0, 9'd120, 1'b0, 16'hFFFF, 16'h00FF);
    place_sprite(4, 9'd124, 1'b0, 16'hFFFF, 16'hFFFF);
    place_sprite(3, 9'd300, 1'b0, 16'h0FF0, 16'hF00F);
    wait_lines(1);
    bus_write(`SPRITE_MASK_ADDR, 16'h00FE);  // sprite 0 gone, 4 shows
    wait_lines(1);
    bus_write(`SPRITE_MASK_ADDR, 16'h00E6);  // 0, 3 and 4 hidden
    wait_lines(1);
    bus_write(`SPRITE_MASK_ADDR, 16'h00FF);
    wait_lines(1);
    close_test();
  endtask

  task automatic enable_gaps();
    open_test("pix_en_gaps");
    disarm_all();
    gaps_on <= 1'b1;
    place_sprite(1, 9'd50, 1'b0, 16'($urandom), 16'($urandom));
    place_sprite(6, 9'd58, 1'b0, 16'($urandom), 16'($urandom));
    wait_lines(2);
    stray_write(`SPRITE_MASK_ADDR, 16'h0000);
    stray_write(reg_address(1, spr_ctl), 16'h0000);
    wait_lines(1);
    gaps_on <= 1'b0;
    close_test();
  endtask

  task automatic random_regression();
    logic att;
    open_test("random");
    for (int round = 0; round < 4; round++) begin
      for (int n = 0; n < `SPRITE_COUNT; n++) begin
        att = (n % 2 == 1) && ($urandom % 2 == 1);  // odd sprites only
        place_sprite(n, 9'($urandom % 380), att, 16'($urandom), 16'($urandom));
      end
      if (round == 2)
        bus_write(`SPRITE_MASK_ADDR, {8'h00, 8'($urandom)});
      wait_lines(2);
    end
    bus_write(`SPRITE_MASK_ADDR, 16'h00FF);
    close_test();
  endtask

  // --------------------
  // main sequence and watchdog
  // --------------------
  initial begin
    void'($urandom(32'h657bd89a));
    reset        = 1'b1;
    reg_wr       = 1'b0;
    reg_addr     = '0;
    reg_data     = '0;
    gaps_on      = 1'b0;
    pix_hold     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    reset_and_arming();
    pair_priority();
    attached_pairs();
    global_mask();
    enable_gaps();
    random_regression();
    $display("%0d tests run, %0d with errors, %0d checks failed",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial begin
    #((TEST_LINES + SPARE_LINES) * LINE_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired, the run did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
hw/sprite_pkg.sv
hw/sprite_reg_decode.sv
hw/sprite_shifter.sv
hw/sprite_priority.sv
hw/sprite_engine.sv
verification/sprite_engine_tb.sv

/* Makefile */
TOP = sprite_engine_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
